/* hw/serv_pkg.sv */
package serv_pkg;

   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;
   localparam int CNT_W      = 5;

   localparam logic [XLEN-1:0] RESET_PC = 32'd0;
   localparam logic [XLEN-1:0] PC_STEP  = 32'd4;

   // Major opcodes handled by the core
   typedef enum logic [6:0] {
      OP     = 7'b0110011,
      OP_IMM = 7'b0010011,
      LUI    = 7'b0110111,
      BRANCH = 7'b1100011,
      STORE  = 7'b0100011
   } opcode_t;

   typedef enum logic [2:0] {
      ADD,
      SUB,
      XOR,
      OR,
      AND
   } alu_op_t;

   // COMPARE is the first of the two passes a branch takes
   typedef enum logic [1:0] {
      FETCH,
      EXEC,
      COMPARE,
      STORE_WAIT
   } phase_t;

endpackage

/* hw/core_ctrl_if.sv */
`timescale 1ns/1ps

interface core_ctrl_if;

   logic [serv_pkg::REG_ADDR_W-1:0] rs1_addr;
   logic [serv_pkg::REG_ADDR_W-1:0] rs2_addr;
   logic [serv_pkg::REG_ADDR_W-1:0] rd_addr;
   logic                            imm_bit;
   logic                            use_imm;
   serv_pkg::alu_op_t               alu_op;
   logic                            rd_wen;
   logic                            is_branch;
   logic                            branch_ne;
   logic                            is_store;

   modport decoder (output rs1_addr, rs2_addr, rd_addr, imm_bit, use_imm, alu_op,
                    rd_wen, is_branch, branch_ne, is_store);
   modport sequencer (input is_branch, branch_ne, is_store);
   modport exec (input use_imm, alu_op, imm_bit);
   modport result (input rs1_addr, rs2_addr, rd_addr, rd_wen, imm_bit);

endinterface

/* hw/cycle_state.sv */
`timescale 1ns/1ps

module cycle_state (
   input  logic                       i_clk,
   input  logic                       i_rst_n,
   core_ctrl_if.sequencer             ctrl,
   input  logic                       i_ibus_ack,
   input  logic                       i_dbus_ack,
   input  logic                       i_eq,
   output logic                       o_ibus_cyc,
   output logic                       o_dbus_cyc,
   output logic [serv_pkg::CNT_W-1:0] o_cnt,
   output logic                       o_cnt_done,
   output logic                       o_exec_en,
   output logic                       o_wr_en,
   output logic                       o_pc_upd,
   output logic                       o_branch_taken
);

   serv_pkg::phase_t state_q;
   serv_pkg::phase_t phase;
   logic             active;
   logic             cmp_done;
   logic             taken_q;

   assign active = (state_q == serv_pkg::EXEC);

   // A branch spends its first pass comparing rs1 with rs2
   assign phase = (active && ctrl.is_branch && !cmp_done) ? serv_pkg::COMPARE : state_q;

   assign o_ibus_cyc     = (state_q == serv_pkg::FETCH);
   assign o_dbus_cyc     = (state_q == serv_pkg::STORE_WAIT);
   assign o_exec_en      = active;
   assign o_cnt_done     = active && (o_cnt == '1);
   assign o_wr_en        = (phase == serv_pkg::EXEC) && !ctrl.is_branch && !ctrl.is_store;
   assign o_pc_upd       = (phase == serv_pkg::EXEC);
   assign o_branch_taken = taken_q;

   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         state_q  <= serv_pkg::FETCH;
         o_cnt    <= '0;
         cmp_done <= 1'b0;
         taken_q  <= 1'b0;
      end else begin
         if (active) begin
            o_cnt <= o_cnt + {{(serv_pkg::CNT_W-1){1'b0}}, 1'b1};
         end
         case (state_q)
            serv_pkg::FETCH: begin
               if (i_ibus_ack) begin
                  state_q  <= serv_pkg::EXEC;
                  cmp_done <= 1'b0;
                  taken_q  <= 1'b0;
               end
            end
            serv_pkg::EXEC: begin
               if (o_cnt_done) begin
                  if (phase == serv_pkg::COMPARE) begin
                     cmp_done <= 1'b1;
                     taken_q  <= i_eq ^ ctrl.branch_ne;
                  end else if (ctrl.is_store) begin
                     state_q <= serv_pkg::STORE_WAIT;
                  end else begin
                     state_q <= serv_pkg::FETCH;
                  end
               end
            end
            serv_pkg::STORE_WAIT: begin
               if (i_dbus_ack) begin
                  state_q <= serv_pkg::FETCH;
               end
            end
            default: state_q <= serv_pkg::FETCH;
         endcase
      end
   end

   a_one_bus_at_a_time: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      !(o_ibus_cyc && o_dbus_cyc));

endmodule

/* hw/instr_decode.sv */
`timescale 1ns/1ps

module instr_decode (
   input  logic                       i_clk,
   input  logic [serv_pkg::XLEN-1:0]  i_ibus_rdt,
   input  logic                       i_ibus_ack,
   input  logic [serv_pkg::CNT_W-1:0] i_cnt,
   core_ctrl_if.decoder               ctrl
);

   logic [serv_pkg::XLEN-1:0] instr;
   logic [serv_pkg::XLEN-1:0] imm;
   serv_pkg::opcode_t         opcode;
   logic [2:0]                funct3;

   always_ff @(posedge i_clk) begin
      if (i_ibus_ack) begin
         instr <= i_ibus_rdt;
      end
   end

   assign opcode = serv_pkg::opcode_t'(instr[6:0]);
   assign funct3 = instr[14:12];

   assign ctrl.rd_addr   = instr[11:7];
   assign ctrl.rs2_addr  = instr[24:20];
   // LUI adds its immediate to x0
   assign ctrl.rs1_addr  = (opcode == serv_pkg::LUI) ? '0 : instr[19:15];
   assign ctrl.branch_ne = funct3[0];
   assign ctrl.imm_bit   = imm[i_cnt];

   always_comb begin
      ctrl.use_imm   = 1'b0;
      ctrl.alu_op    = serv_pkg::ADD;
      ctrl.rd_wen    = 1'b0;
      ctrl.is_branch = 1'b0;
      ctrl.is_store  = 1'b0;
      imm            = {{20{instr[31]}}, instr[31:20]};
      case (opcode)
         serv_pkg::OP, serv_pkg::OP_IMM: begin
            ctrl.use_imm = (opcode == serv_pkg::OP_IMM);
            ctrl.rd_wen  = 1'b1;
            case (funct3)
               3'b000: begin
                  if (opcode == serv_pkg::OP && instr[30]) begin
                     ctrl.alu_op = serv_pkg::SUB;
                  end
               end
               3'b100:  ctrl.alu_op = serv_pkg::XOR;
               3'b110:  ctrl.alu_op = serv_pkg::OR;
               3'b111:  ctrl.alu_op = serv_pkg::AND;
               // Shifts and compares are not implemented
               default: ctrl.rd_wen = 1'b0;
            endcase
         end
         serv_pkg::LUI: begin
            ctrl.use_imm = 1'b1;
            ctrl.rd_wen  = 1'b1;
            imm          = {instr[31:12], 12'b0};
         end
         serv_pkg::BRANCH: begin
            ctrl.is_branch = 1'b1;
            ctrl.alu_op    = serv_pkg::SUB;
            imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
         end
         serv_pkg::STORE: begin
            ctrl.is_store = 1'b1;
            ctrl.use_imm  = 1'b1;
            imm           = {{20{instr[31]}}, instr[31:25], instr[11:7]};
         end
         default: ;
      endcase
   end

endmodule

/* hw/serial_alu.sv */
`timescale 1ns/1ps

module serial_alu (
   input  logic                       i_clk,
   core_ctrl_if.exec                  ctrl,
   input  logic                       i_exec_en,
   input  logic                       i_cnt_done,
   input  logic [serv_pkg::CNT_W-1:0] i_cnt,
   input  logic                       i_rs1,
   input  logic                       i_rs2,
   output logic                       o_rd,
   output logic                       o_sum,
   output logic                       o_eq
);

   logic op_b;
   logic b_in;
   logic sub;
   logic cin;
   logic carry_q;
   logic eq_q;

   assign sub  = (ctrl.alu_op == serv_pkg::SUB);
   assign op_b = ctrl.use_imm ? ctrl.imm_bit : i_rs2;
   assign b_in = op_b ^ sub;

   // Carry in of one at bit 0 completes the two's complement
   assign cin   = (i_cnt == '0) ? sub : carry_q;
   assign o_sum = i_rs1 ^ b_in ^ cin;
   assign o_eq  = ((i_cnt == '0) || eq_q) && (i_rs1 == op_b);

   always_comb begin
      case (ctrl.alu_op)
         serv_pkg::XOR: o_rd = i_rs1 ^ op_b;
         serv_pkg::OR:  o_rd = i_rs1 | op_b;
         serv_pkg::AND: o_rd = i_rs1 & op_b;
         default:       o_rd = o_sum;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_exec_en) begin
         carry_q <= (i_rs1 & b_in) | (cin & (i_rs1 ^ b_in));
         eq_q    <= o_eq;
      end
   end

   // Operation and operand select hold for the whole pass
   a_op_stable_in_pass: assert property (@(posedge i_clk)
      (i_exec_en && !i_cnt_done) |=> ($stable(ctrl.alu_op) && $stable(ctrl.use_imm)));

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
   input  logic                       i_clk,
   core_ctrl_if.result                ctrl,
   input  logic [serv_pkg::CNT_W-1:0] i_cnt,
   input  logic                       i_wr_en,
   input  logic                       i_rd,
   output logic                       o_rs1,
   output logic                       o_rs2
);

   logic [serv_pkg::XLEN-1:0] regs [2**serv_pkg::REG_ADDR_W];

   assign o_rs1 = (ctrl.rs1_addr == '0) ? 1'b0 : regs[ctrl.rs1_addr][i_cnt];
   assign o_rs2 = (ctrl.rs2_addr == '0) ? 1'b0 : regs[ctrl.rs2_addr][i_cnt];

   // Bits above cnt are still the old value, so rd may equal a source
   always_ff @(posedge i_clk) begin
      if (i_wr_en && ctrl.rd_wen && ctrl.rd_addr != '0) begin
         regs[ctrl.rd_addr][i_cnt] <= i_rd;
      end
   end

   a_x0_constant: assert property (@(posedge i_clk) $stable(regs[0]));

endmodule

/* hw/pc_ctrl.sv */
`timescale 1ns/1ps

module pc_ctrl (
   input  logic                       i_clk,
   input  logic                       i_rst_n,
   core_ctrl_if.result                ctrl,
   input  logic [serv_pkg::CNT_W-1:0] i_cnt,
   input  logic                       i_pc_upd,
   input  logic                       i_branch_taken,
   output logic [serv_pkg::XLEN-1:0]  o_ibus_adr
);

   logic [serv_pkg::XLEN-1:0] pc;
   logic [serv_pkg::XLEN-1:0] shadow;
   logic                      addend;
   logic                      cin;
   logic                      carry_q;
   logic                      sum;

   assign addend = i_branch_taken ? ctrl.imm_bit : serv_pkg::PC_STEP[i_cnt];
   assign cin    = (i_cnt == '0) ? 1'b0 : carry_q;
   assign sum    = pc[i_cnt] ^ addend ^ cin;

   always_ff @(posedge i_clk) begin
      if (i_pc_upd) begin
         shadow  <= {sum, shadow[serv_pkg::XLEN-1:1]};
         carry_q <= (pc[i_cnt] & addend) | (cin & (pc[i_cnt] ^ addend));
      end
   end

   // Bits 0 to 30 sit in the shadow when the last bit arrives
   always_ff @(posedge i_clk) begin
      if (!i_rst_n) begin
         pc <= serv_pkg::RESET_PC;
      end else if (i_pc_upd && i_cnt == '1) begin
         pc <= {sum, shadow[serv_pkg::XLEN-1:1]};
      end
   end

   assign o_ibus_adr = pc;

   a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      o_ibus_adr[1:0] == 2'b00);

endmodule

/* hw/store_unit.sv */
`timescale 1ns/1ps

module store_unit (
   input  logic                      i_clk,
   input  logic                      i_exec_en,
   input  logic                      i_sum,
   input  logic                      i_rs2,
   output logic [serv_pkg::XLEN-1:0] o_dbus_adr,
   output logic [serv_pkg::XLEN-1:0] o_dbus_dat
);

   logic [serv_pkg::XLEN-1:0] adr_q;
   logic [serv_pkg::XLEN-1:0] dat_q;

   // LSB first, so bit 0 reaches position 0 after the full pass
   always_ff @(posedge i_clk) begin
      if (i_exec_en) begin
         adr_q <= {i_sum, adr_q[serv_pkg::XLEN-1:1]};
         dat_q <= {i_rs2, dat_q[serv_pkg::XLEN-1:1]};
      end
   end

   // Held while dbus waits since no pass runs then
   assign o_dbus_adr = adr_q;
   assign o_dbus_dat = dat_q;

endmodule

/* hw/serial_core_top.sv */
`timescale 1ns/1ps

module serial_core_top (
   input  logic                      i_clk,
   input  logic                      i_rst_n,
   output logic [serv_pkg::XLEN-1:0] o_ibus_adr,
   output logic                      o_ibus_cyc,
   input  logic [serv_pkg::XLEN-1:0] i_ibus_rdt,
   input  logic                      i_ibus_ack,
   output logic [serv_pkg::XLEN-1:0] o_dbus_adr,
   output logic [serv_pkg::XLEN-1:0] o_dbus_dat,
   output logic                      o_dbus_we,
   output logic                      o_dbus_cyc,
   input  logic                      i_dbus_ack
);

   logic [serv_pkg::CNT_W-1:0] cnt;
   logic                       cnt_done;
   logic                       exec_en;
   logic                       wr_en;
   logic                       pc_upd;
   logic                       branch_taken;
   logic                       dbus_cyc;
   logic                       alu_rd;
   logic                       sum;
   logic                       eq;
   logic                       rs1;
   logic                       rs2;

   core_ctrl_if ctrl_if ();

   // Only stores use dbus
   assign o_dbus_cyc = dbus_cyc;
   assign o_dbus_we  = dbus_cyc;

   cycle_state cycle_state_inst (
      .i_clk          (i_clk),
      .i_rst_n        (i_rst_n),
      .ctrl           (ctrl_if.sequencer),
      .i_ibus_ack     (i_ibus_ack),
      .i_dbus_ack     (i_dbus_ack),
      .i_eq           (eq),
      .o_ibus_cyc     (o_ibus_cyc),
      .o_dbus_cyc     (dbus_cyc),
      .o_cnt          (cnt),
      .o_cnt_done     (cnt_done),
      .o_exec_en      (exec_en),
      .o_wr_en        (wr_en),
      .o_pc_upd       (pc_upd),
      .o_branch_taken (branch_taken)
   );

   instr_decode instr_decode_inst (
      .i_clk      (i_clk),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .i_cnt      (cnt),
      .ctrl       (ctrl_if.decoder)
   );

   serial_alu serial_alu_inst (
      .i_clk      (i_clk),
      .ctrl       (ctrl_if.exec),
      .i_exec_en  (exec_en),
      .i_cnt_done (cnt_done),
      .i_cnt      (cnt),
      .i_rs1      (rs1),
      .i_rs2      (rs2),
      .o_rd       (alu_rd),
      .o_sum      (sum),
      .o_eq       (eq)
   );

   reg_file reg_file_inst (
      .i_clk   (i_clk),
      .ctrl    (ctrl_if.result),
      .i_cnt   (cnt),
      .i_wr_en (wr_en),
      .i_rd    (alu_rd),
      .o_rs1   (rs1),
      .o_rs2   (rs2)
   );

   pc_ctrl pc_ctrl_inst (
      .i_clk          (i_clk),
      .i_rst_n        (i_rst_n),
      .ctrl           (ctrl_if.result),
      .i_cnt          (cnt),
      .i_pc_upd       (pc_upd),
      .i_branch_taken (branch_taken),
      .o_ibus_adr     (o_ibus_adr)
   );

   store_unit store_unit_inst (
      .i_clk      (i_clk),
      .i_exec_en  (exec_en),
      .i_sum      (sum),
      .i_rs2      (rs2),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat)
   );

endmodule

/* verification/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
   output logic o_clk
);

   // 100 ns period
   initial begin
      o_clk = 1'b0;
      forever begin
         #50 o_clk = ~o_clk;
      end
   end

endmodule

/* verification/core_tb.sv */
`timescale 1ns/1ps

module core_tb;

   localparam int RESET_CYCLES = 10;
   localparam int WAIT_LIMIT   = 1000;

   logic        clk;
   logic        rst_n      = 1'b0;
   logic        ibus_ack   = 1'b0;
   logic        dbus_ack   = 1'b0;
   logic [31:0] ibus_rdt   = '0;
   logic [31:0] ibus_adr;
   logic        ibus_cyc;
   logic [31:0] dbus_adr;
   logic [31:0] dbus_dat;
   logic        dbus_we;
   logic        dbus_cyc;

   // Program image and its expected effects
   logic [31:0] prog      [64];
   logic [31:0] xr        [32] = '{default: '0};
   logic [31:0] exp_fetch [64];
   logic [31:0] exp_adr   [64];
   logic [31:0] exp_dat   [64];
   logic [31:0] asm_pc;
   logic [31:0] loop_adr;
   logic [5:0]  n_fetch;
   logic [5:0]  n_store;
   logic [9:0]  st_num;
   logic        skip_next;
   logic        live;

   logic [5:0]  fetch_idx;
   logic [5:0]  store_idx;
   logic [31:0] exp_fetch_adr;
   logic [31:0] exp_store_adr;
   logic [31:0] exp_store_dat;
   logic        reset_seen = 1'b0;
   int          loop_hits;
   int          rst_count  = 0;
   int          idle_left  = -1;
   int          seed       = 32'h3837;

   tb_clock clock_gen (.o_clk(clk));

   serial_core_top serial_core_top_inst (
      .i_clk      (clk),
      .i_rst_n    (rst_n),
      .o_ibus_adr (ibus_adr),
      .o_ibus_cyc (ibus_cyc),
      .i_ibus_rdt (ibus_rdt),
      .i_ibus_ack (ibus_ack),
      .o_dbus_adr (dbus_adr),
      .o_dbus_dat (dbus_dat),
      .o_dbus_we  (dbus_we),
      .o_dbus_cyc (dbus_cyc),
      .i_dbus_ack (dbus_ack)
   );

   task automatic abort_run();
      $display("SOME TESTS FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic flag_mismatch(input string msg);
      $display("mismatch at %0t: %s", $time, msg);
      abort_run();
   endtask

   task automatic report_failure(input string msg);
      $display("%s", msg);
      abort_run();
   endtask

   function automatic logic [31:0] rv32i_result(input logic [2:0] f3, input logic sub,
                                                input logic [31:0] a, input logic [31:0] b);
      case (f3)
         3'b000:  return sub ? a - b : a + b;
         3'b100:  return a ^ b;
         3'b110:  return a | b;
         3'b111:  return a & b;
         default: return '0;
      endcase
   endfunction

   task automatic place_word(input logic [31:0] word);
      live      = !skip_next;
      skip_next = 1'b0;
      prog[asm_pc[7:2]] = word;
      if (live) begin
         exp_fetch[n_fetch] = asm_pc;
         n_fetch = n_fetch + 6'd1;
      end
      asm_pc = asm_pc + 32'd4;
   endtask

   task automatic write_xreg(input logic [4:0] rd, input logic [31:0] value);
      if (live && rd != 5'd0) begin
         xr[rd] = value;
      end
   endtask

   task automatic load_upper(input logic [4:0] rd, input logic [19:0] imm);
      place_word({imm, rd, 7'b0110111});
      write_xreg(rd, {imm, 12'h000});
   endtask

   task automatic imm_alu(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
      place_word({imm, rs1, f3, rd, 7'b0010011});
      write_xreg(rd, rv32i_result(f3, 1'b0, xr[rs1], {{20{imm[11]}}, imm}));
   endtask

   task automatic reg_alu(input logic [2:0] f3, input logic sub, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2);
      place_word({1'b0, sub, 5'b00000, rs2, rs1, f3, rd, 7'b0110011});
      write_xreg(rd, rv32i_result(f3, sub, xr[rs1], xr[rs2]));
   endtask

   // Base register x5, every store gets its own offset
   task automatic store_word(input logic [4:0] rs2);
      logic [11:0] off;
      off    = 12'hff0 + {st_num, 2'b00};
      st_num = st_num + 10'd1;
      place_word({off[11:5], rs2, 5'd5, 3'b010, off[4:0], 7'b0100011});
      if (live) begin
         exp_adr[n_store] = xr[5] + {{20{off[11]}}, off};
         exp_dat[n_store] = xr[rs2];
         n_store = n_store + 6'd1;
      end
   endtask

   task automatic branch_cmp(input logic ne, input logic [4:0] rs1, input logic [4:0] rs2,
                             input logic [12:0] off);
      place_word({off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], 7'b1100011});
      // Offset 8 jumps over exactly one word
      if (live && ((xr[rs1] == xr[rs2]) ^ ne)) begin
         skip_next = (off == 13'd8);
      end
   endtask

   task automatic build_program();
      asm_pc    = serv_pkg::RESET_PC;
      n_fetch   = '0;
      n_store   = '0;
      st_num    = '0;
      skip_next = 1'b0;
      load_upper(5'd5, 20'h00001);
      store_word(5'd5);
      load_upper(5'd1, 20'hdeadb);
      store_word(5'd1);
      imm_alu(3'b000, 5'd2, 5'd1, 12'heef);
      store_word(5'd2);
      imm_alu(3'b000, 5'd3, 5'd0, 12'h5a5);
      store_word(5'd3);
      reg_alu(3'b000, 1'b0, 5'd4, 5'd2, 5'd3);
      store_word(5'd4);
      reg_alu(3'b000, 1'b1, 5'd6, 5'd3, 5'd2);
      store_word(5'd6);
      reg_alu(3'b100, 1'b0, 5'd7, 5'd2, 5'd3);
      store_word(5'd7);
      reg_alu(3'b110, 1'b0, 5'd8, 5'd2, 5'd3);
      store_word(5'd8);
      reg_alu(3'b111, 1'b0, 5'd9, 5'd2, 5'd3);
      store_word(5'd9);
      imm_alu(3'b100, 5'd10, 5'd2, 12'hfff);
      store_word(5'd10);
      imm_alu(3'b110, 5'd11, 5'd3, 12'h70f);
      store_word(5'd11);
      imm_alu(3'b111, 5'd12, 5'd2, 12'h7f0);
      store_word(5'd12);
      branch_cmp(1'b0, 5'd3, 5'd3, 13'd8);
      store_word(5'd1);
      branch_cmp(1'b1, 5'd3, 5'd3, 13'd8);
      store_word(5'd4);
      branch_cmp(1'b1, 5'd2, 5'd3, 13'd8);
      store_word(5'd6);
      loop_adr = asm_pc;
      branch_cmp(1'b0, 5'd0, 5'd0, 13'd0);
   endtask

   always @(posedge clk) begin
      if (rst_count < RESET_CYCLES - 1) begin
         rst_count <= rst_count + 1;
      end else begin
         rst_n <= 1'b1;
      end
   end

   // ibus and dbus responders, 0 to 3 idle cycles per request
   always @(posedge clk) begin : respond
      int delay;
      if (!rst_n || ibus_ack || dbus_ack) begin
         ibus_ack  <= 1'b0;
         dbus_ack  <= 1'b0;
         idle_left <= -1;
      end else if (ibus_cyc || dbus_cyc) begin
         delay = (idle_left < 0) ? ($random(seed) & 3) : idle_left;
         if (delay == 0) begin
            idle_left <= -1;
            ibus_ack  <= ibus_cyc;
            dbus_ack  <= dbus_cyc;
            ibus_rdt  <= prog[ibus_adr[7:2]];
         end else begin
            idle_left <= delay - 1;
         end
      end
   end

   always @(posedge clk) begin
      if (!rst_n) begin
         reset_seen <= 1'b1;
         fetch_idx  <= '0;
         store_idx  <= '0;
         loop_hits  <= 0;
      end else begin
         if (ibus_ack) begin
            fetch_idx <= fetch_idx + 6'd1;
            if (ibus_adr == loop_adr) begin
               loop_hits <= loop_hits + 1;
            end
         end
         if (dbus_ack) begin
            store_idx <= store_idx + 6'd1;
         end
      end
   end

   // Past the end of the trace the core keeps spinning on the self-loop
   always_comb begin
      exp_fetch_adr = (fetch_idx < n_fetch) ? exp_fetch[fetch_idx] : loop_adr;
      exp_store_adr = exp_adr[store_idx];
      exp_store_dat = exp_dat[store_idx];
   end

   a_reset_outputs: assert property (@(posedge clk)
      (reset_seen && (!rst_n || $rose(rst_n))) |->
      (!dbus_cyc && !dbus_we && ibus_cyc && ibus_adr == serv_pkg::RESET_PC))
      else flag_mismatch("bus outputs not in their reset state");

   a_ibus_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (ibus_cyc && !ibus_ack) |=> (ibus_cyc && $stable(ibus_adr)))
      else flag_mismatch("ibus request changed before its ack");

   a_dbus_hold: assert property (@(posedge clk) disable iff (!rst_n)
      (dbus_cyc && !dbus_ack) |=>
      (dbus_cyc && dbus_we && $stable(dbus_adr) && $stable(dbus_dat)))
      else flag_mismatch("dbus request changed before its ack");

   a_ibus_release: assert property (@(posedge clk) disable iff (!rst_n)
      ibus_ack |=> !ibus_cyc)
      else flag_mismatch("ibus cyc still high after ack");

   a_dbus_release: assert property (@(posedge clk) disable iff (!rst_n)
      dbus_ack |=> !dbus_cyc)
      else flag_mismatch("dbus cyc still high after ack");

   a_fetch_aligned: assert property (@(posedge clk) disable iff (!rst_n)
      ibus_cyc |-> ibus_adr[1:0] == 2'b00)
      else flag_mismatch("fetch address not word aligned");

   a_single_bus: assert property (@(posedge clk) disable iff (!rst_n)
      !(ibus_cyc && dbus_cyc))
      else report_failure("ibus and dbus were requested in the same cycle");

   a_fetch_order: assert property (@(posedge clk) disable iff (!rst_n)
      ibus_ack |-> ibus_adr == exp_fetch_adr)
      else flag_mismatch("fetch address differs from the program flow");

   a_store_count: assert property (@(posedge clk) disable iff (!rst_n)
      dbus_ack |-> store_idx < n_store)
      else report_failure("the core made a store that the program does not contain");

   a_store_value: assert property (@(posedge clk) disable iff (!rst_n)
      dbus_ack |-> (dbus_adr == exp_store_adr && dbus_dat == exp_store_dat))
      else flag_mismatch("store address or data wrong");

   task automatic await_store();
      logic [5:0] start;
      int         cycles;
      start  = store_idx;
      cycles = 0;
      while (store_idx == start && cycles < WAIT_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      if (store_idx == start) begin
         report_failure("no store reached dbus within the timeout");
      end
   endtask

   task automatic wait_loop_fetches();
      int cycles;
      cycles = 0;
      while (loop_hits < 2 && cycles < WAIT_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      if (loop_hits < 2) begin
         report_failure("the final self-loop was not fetched twice within the timeout");
      end
   endtask

   initial begin
      build_program();
      repeat (RESET_CYCLES + 1) @(posedge clk);
      while (store_idx != n_store) begin
         await_store();
      end
      wait_loop_fetches();
      if (store_idx == n_store) begin
         $display("ALL TESTS PASSED");
         $finish;
      end else begin
         report_failure("number of stores differs from the expected table");
      end
   end

endmodule

/* src.f */
hw/serv_pkg.sv
hw/core_ctrl_if.sv
hw/cycle_state.sv
hw/instr_decode.sv
hw/serial_alu.sv
hw/reg_file.sv
hw/pc_ctrl.sv
hw/store_unit.sv
hw/serial_core_top.sv
verification/tb_clock.sv
verification/core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= core_tb
BUILD_DIR ?= build
FILELIST  ?= src.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator and run it"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP BUILD_DIR FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
